// ==== all.f ====
+incdir+include
verilog/adc_pkg.sv
verilog/sine_source.sv
verilog/sar_quantizer.sv
verilog/clock_divider.sv
verilog/lane_deinterleaver.sv
verilog/ti_adc_model.sv
tb/tb_ti_adc_model.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_ti_adc_model
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module "$top" -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

./obj_dir/V$top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
    echo "Result: FAIL"
    exit 1
fi

echo "Result: PASS"
exit 0

// ==== tb/tb_ti_adc_model.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module tb_ti_adc_model;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int FRAME_CYCLES   = `WIDE_LANES;
    localparam int FIRST_PULSE    = 2 + `WIDE_LANES; // Beat 95 lands at 97 and the pulse follows
    localparam int WIDE_W         = `WIDE_LANES * `CODE_W;
    localparam int NARROW_W       = `NARROW_LANES * `CODE_W;

    logic clk = 1'b0;
    logic reset;
    logic wide_en;
    logic narrow_en;

    logic [WIDE_W-1:0]   wide_frame;
    logic                wide_valid;
    logic [NARROW_W-1:0] narrow_frame;
    logic                narrow_valid;
    logic                frame_clk;
    logic                reg_clk;

    int cycle         = 0;
    int since_release = 0; // Clocks since the edge that released reset
    int errors        = 0;
    int checks        = 0;

    adc_pkg::sample_t ref_lut [0:`SINE_DEPTH-1];

    ti_adc_model i_ti_adc_model (
        .clk          (clk),
        .reset        (reset),
        .wide_en      (wide_en),
        .narrow_en    (narrow_en),
        .wide_frame   (wide_frame),
        .wide_valid   (wide_valid),
        .narrow_frame (narrow_frame),
        .narrow_valid (narrow_valid),
        .frame_clk    (frame_clk),
        .reg_clk      (reg_clk)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            since_release <= 0;
        end else begin
            since_release <= since_release + 1;
        end
    end

    // Nearest integer with halves rounded away from zero
    function automatic adc_pkg::sample_t round_sine(input int p);
        real x;
        real r;
        x = $sin(2.0 * 3.14159265358979323846 * real'(p) / real'(`SINE_DEPTH));
        x = x * real'(`SINE_AMPL);
        if (x < 0.0) begin
            r = -$floor(-x + 0.5);
        end else begin
            r = $floor(x + 0.5);
        end
        return adc_pkg::sample_t'($rtoi(r));
    endfunction

    function automatic adc_pkg::code_t expected_code(input int s);
        int             residual;
        int             weight;
        adc_pkg::code_t c;
        residual = s;
        c        = '0;
        for (int k = `CODE_W - 1; k >= 0; k--) begin
            weight = `SAR_UNIT * (1 << k);
            if (residual > 0) begin
                c[k]     = 1'b1;
                residual = residual - weight;
            end else begin
                residual = residual + weight; // Bit stays 0
            end
        end
        return c;
    endfunction

    function automatic adc_pkg::code_t code_for_phase(input int phase);
        return expected_code(int'(ref_lut[phase % `SINE_DEPTH]));
    endfunction

    task automatic build_reference();
        for (int p = 0; p < `SINE_DEPTH; p++) begin
            ref_lut[p] = round_sine(p);
        end
    endtask

    task automatic check_bit(input string what, input logic actual, input logic expected);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Lane j of frame f holds phase 96f + stride*j
    task automatic check_slots(input string path, input int f, input int lanes,
                               input int stride, input logic [WIDE_W-1:0] data);
        adc_pkg::code_t expected;
        adc_pkg::code_t actual;
        for (int j = 0; j < lanes; j++) begin
            expected = code_for_phase(FRAME_CYCLES * f + stride * j);
            actual   = data[j*`CODE_W +: `CODE_W];
            checks++;
            assert (actual === expected) else begin
                errors++;
                $display("Mismatch at %0t: %s frame %0d lane %0d is %h, expected %h",
                         $time, path, f, j, actual, expected);
            end
        end
    endtask

    task automatic check_reset_state();
        check_bit("wide_valid", wide_valid, 1'b0);
        check_bit("narrow_valid", narrow_valid, 1'b0);
        check_bit("wide_frame cleared", wide_frame === '0, 1'b1);
        check_bit("narrow_frame cleared", narrow_frame === '0, 1'b1);
        check_bit("frame_clk", frame_clk, 1'b0);
        check_bit("reg_clk", reg_clk, 1'b0);
        check_bit("sample_valid", i_ti_adc_model.sample_valid, 1'b0);
    endtask

    task automatic check_narrow_held(input logic [NARROW_W-1:0] held);
        check_bit("narrow_valid while idle", narrow_valid, 1'b0);
        checks++;
        assert (narrow_frame === held) else begin
            errors++;
            $display("Mismatch at %0t: narrow_frame changed while no frame was published",
                     $time);
        end
    endtask

    task automatic wait_wide_pulse();
        do begin
            @(negedge clk);
        end while (wide_valid !== 1'b1);
    endtask

    task automatic test_enabled_frames();
        for (int f = 0; f < 6; f++) begin // Frame 5 wraps past phase 511
            wait_wide_pulse();
            check_slots("wide", f, `WIDE_LANES, 1, wide_frame);
            check_bit("narrow_valid with wide_valid", narrow_valid, 1'b1);
            check_slots("narrow", f, `NARROW_LANES, 2, WIDE_W'(narrow_frame));
        end
    endtask

    task automatic test_narrow_enable();
        logic [NARROW_W-1:0] held;
        @(posedge clk);
        narrow_en <= 1'b0;
        held = narrow_frame;
        for (int f = 6; f < 8; f++) begin
            wait_wide_pulse();
            check_slots("wide", f, `WIDE_LANES, 1, wide_frame);
            check_narrow_held(held);
        end
        repeat (40) @(posedge clk);
        narrow_en <= 1'b1; // Middle of frame 8
        wait_wide_pulse();
        check_slots("wide", 8, `WIDE_LANES, 1, wide_frame);
        check_narrow_held(held);
        wait_wide_pulse();
        check_slots("wide", 9, `WIDE_LANES, 1, wide_frame);
        check_bit("narrow_valid after enable", narrow_valid, 1'b1);
        check_slots("narrow", 9, `NARROW_LANES, 2, WIDE_W'(narrow_frame));
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Checks: %0d, errors: %0d, timeout: %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    // Divider levels and wide pulses follow fixed cycle counts
    initial begin : timing_monitor
        logic expect_wide;
        forever begin
            @(negedge clk);
            expect_wide = since_release >= FIRST_PULSE
                          && (since_release - FIRST_PULSE) % FRAME_CYCLES == 0;
            check_bit("wide_valid", wide_valid, expect_wide);
            check_bit("frame_clk", frame_clk, logic'((since_release / `FRAME_HALF) % 2));
            check_bit("reg_clk", reg_clk, logic'((since_release / `REG_HALF) % 2));
            if (narrow_valid === 1'b1) begin
                check_bit("wide_valid alongside narrow_valid", wide_valid, 1'b1);
            end
        end
    end

    initial begin : timeout_guard
        while (cycle < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        finish_run(1'b1);
    end

    initial begin : run_tests
        reset     = 1'b1;
        wide_en   = 1'b1;
        narrow_en = 1'b1;
        build_reference();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_reset_state();  // First clock after release
        test_enabled_frames();
        test_narrow_enable();
        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

// ==== verilog/ti_adc_model.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module ti_adc_model (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wide_en,
    input  logic                                narrow_en,
    output logic [`WIDE_LANES*`CODE_W-1:0]      wide_frame,
    output logic                                wide_valid,
    output logic [`NARROW_LANES*`CODE_W-1:0]    narrow_frame,
    output logic                                narrow_valid,
    output logic                                frame_clk,
    output logic                                reg_clk
);

    adc_pkg::sample_t    sample;
    logic                sample_valid;
    adc_pkg::code_beat_t beat;

    sine_source i_sine_source (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    sar_quantizer i_sar_quantizer (
        .clk          (clk),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .beat         (beat)
    );

    // Wide path takes every sample
    lane_deinterleaver #(
        .LANES    (`WIDE_LANES),
        .DECIMATE (1)
    ) i_wide_deinterleaver (
        .clk         (clk),
        .reset       (reset),
        .enable      (wide_en),
        .beat        (beat),
        .frame       (wide_frame),
        .frame_valid (wide_valid)
    );

    // Narrow path takes every second sample over the same frame span
    lane_deinterleaver #(
        .LANES    (`NARROW_LANES),
        .DECIMATE (2)
    ) i_narrow_deinterleaver (
        .clk         (clk),
        .reset       (reset),
        .enable      (narrow_en),
        .beat        (beat),
        .frame       (narrow_frame),
        .frame_valid (narrow_valid)
    );

    clock_divider #(
        .HALF_PERIOD (`FRAME_HALF)
    ) i_frame_clk_div (
        .clk     (clk),
        .reset   (reset),
        .clk_out (frame_clk)
    );

    clock_divider #(
        .HALF_PERIOD (`REG_HALF)
    ) i_reg_clk_div (
        .clk     (clk),
        .reset   (reset),
        .clk_out (reg_clk)
    );

endmodule

// ==== verilog/lane_deinterleaver.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module lane_deinterleaver #(
    parameter int LANES    = 96,
    parameter int DECIMATE = 1
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  adc_pkg::code_beat_t        beat,
    output logic [LANES*`CODE_W-1:0]   frame,
    output logic                       frame_valid
);

    localparam int BEATS  = LANES * DECIMATE;
    localparam int CNT_W  = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int SLOT_W = (LANES > 1) ? $clog2(LANES) : 1;

    logic [CNT_W-1:0]  beat_cnt;
    logic [SLOT_W-1:0] slot;
    logic              selected;
    logic              write_en;
    logic              last_beat;
    logic              armed;
    logic              armed_next;
    logic              publish;

    logic [LANES-1:0][`CODE_W-1:0] staging;
    logic [LANES-1:0][`CODE_W-1:0] staging_next;

    assign selected  = (beat_cnt % DECIMATE) == 0;
    assign slot      = SLOT_W'(beat_cnt / DECIMATE);
    assign write_en  = beat.valid && enable && selected;
    assign last_beat = beat_cnt == CNT_W'(BEATS - 1);

    // A frame stays armed only while enable holds from its first beat on
    assign armed_next = (beat_cnt == '0) ? enable : (armed && enable);
    assign publish    = beat.valid && last_beat && armed_next;

    // Incoming code merged in so the last slot lands in the same frame
    always_comb begin
        staging_next = staging;
        if (write_en) begin
            staging_next[slot] = beat.code;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            beat_cnt <= '0;
            armed    <= 1'b0;
        end else if (beat.valid) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            armed    <= armed_next;
        end
    end

    always_ff @(posedge clk) begin
        staging <= staging_next;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= publish;
            if (publish) begin
                frame <= staging_next; // Holds until the next published frame
            end
        end
    end

endmodule

// ==== verilog/clock_divider.sv ====
`timescale 1ns/1ps

module clock_divider #(
    parameter int HALF_PERIOD = 48
) (
    input  logic clk,
    input  logic reset,
    output logic clk_out
);

    localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count   <= '0;
            clk_out <= 1'b0;
        end else if (count == CNT_W'(HALF_PERIOD - 1)) begin
            count   <= '0;
            clk_out <= ~clk_out; // Toggle once per half period
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== verilog/sar_quantizer.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module sar_quantizer (
    input  logic                clk,
    input  logic                reset,
    input  adc_pkg::sample_t    sample,
    input  logic                sample_valid,
    output adc_pkg::code_beat_t beat
);

    // One guard bit over the sample keeps the residual from overflowing
    logic signed [`SAMPLE_W:0] residual;
    logic signed [`SAMPLE_W:0] step;
    adc_pkg::code_t            code_next;

    adc_pkg::code_t code_q;
    logic           valid_q;

    // Nine sign decisions from the MSB down
    always_comb begin
        residual  = {sample[`SAMPLE_W-1], sample};
        step      = '0;
        code_next = '0;
        for (int k = `CODE_W - 1; k >= 0; k--) begin
            step = (`SAMPLE_W+1)'(`SAR_UNIT << k);
            if (residual > 0) begin
                code_next[k] = 1'b1;
                residual     = residual - step;
            end else begin
                code_next[k] = 1'b0;
                residual     = residual + step;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_valid;
        end
    end

    always_ff @(posedge clk) begin
        code_q <= code_next;
    end

    assign beat.valid = valid_q;
    assign beat.code  = code_q;

endmodule

// ==== verilog/sine_source.sv ====
`timescale 1ns/1ps
`include "adc_consts.svh"

module sine_source (
    input  logic             clk,
    input  logic             reset,
    output adc_pkg::sample_t sample,
    output logic             sample_valid
);

    localparam real PI = 3.14159265358979323846;

    logic [`PHASE_W-1:0] phase;
    adc_pkg::sample_t    sine_lut [0:`SINE_DEPTH-1];

    // Round half away from zero
    function automatic adc_pkg::sample_t sine_entry(input int p);
        real x;
        int  r;
        x = $sin(2.0 * PI * p / `SINE_DEPTH) * `SINE_AMPL;
        if (x >= 0.0) begin
            r = $rtoi(x + 0.5);
        end else begin
            r = -$rtoi(0.5 - x);
        end
        return adc_pkg::sample_t'(r);
    endfunction

    // Table is fixed at elaboration
    for (genvar p = 0; p < `SINE_DEPTH; p++) begin : g_lut
        localparam adc_pkg::sample_t ENTRY = sine_entry(p);
        assign sine_lut[p] = ENTRY;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase        <= '0;
            sample_valid <= 1'b0;
        end else begin
            phase        <= phase + 1'b1; // Wraps at table depth
            sample_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        sample <= sine_lut[phase];
    end

endmodule

// ==== verilog/adc_pkg.sv ====
`include "adc_consts.svh"

package adc_pkg;

    // One sample out of the sine source
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // One conversion result with the MSB decided first
    typedef logic [`CODE_W-1:0] code_t;

    // Code with its strobe for each converted sample
    typedef struct packed {
        logic  valid;
        code_t code;
    } code_beat_t;

endpackage

// ==== include/adc_consts.svh ====
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

// Sine table
`define SINE_DEPTH 512
`define PHASE_W 9

// Signed sample with full scale 1.0 at 32768
`define SAMPLE_W 16
`define SINE_AMPL 16384

// Conversion code and weight of the lowest SAR step
`define CODE_W 9
`define SAR_UNIT 32

// Frame sizes of the two capture paths
`define WIDE_LANES 96
`define NARROW_LANES 48

// Half periods of the divided clocks in clk cycles
`define FRAME_HALF 48
`define REG_HALF 120

`endif
